/* hdl/isaPkg.sv */
`default_nettype none

package isaPkg;

  typedef logic [31:0] word_t;    // data or instruction word
  typedef logic [4:0]  regAddr_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  // primary opcode in instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011
  } opcode_t;

  // function field of RTYPE, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  localparam regAddr_t LINK_REG = 5'd31;  // jal return address

endpackage

`default_nettype wire

/* hdl/pipePkg.sv */
`default_nettype none

package pipePkg;

  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluOp_t;

  localparam isaPkg::word_t PC_INIT   = 32'h0000_0000;
  localparam isaPkg::word_t HALT_WORD = 32'hffff_ffff;  // all ones stops the core

  // each memory holds this many words
  localparam int MEM_WORDS = 256;
  typedef logic [$clog2(MEM_WORDS)-1:0] memAddr_t;

endpackage

`default_nettype wire

/* hdl/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             wen,
  input  isaPkg::regAddr_t wsel,
  input  isaPkg::word_t    wdat,
  input  isaPkg::regAddr_t rsel1,
  input  isaPkg::regAddr_t rsel2,
  output isaPkg::word_t    rdat1,
  output isaPkg::word_t    rdat2
);

  isaPkg::word_t regs [32];

  // entry 0 is cleared by reset and never written
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];  // no write bypass, old value this cycle
  assign rdat2 = regs[rsel2];

  zeroRegStaysZero: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0)
    else $error("register 0 became nonzero");

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  isaPkg::word_t   portA,
  input  isaPkg::word_t   portB,
  input  pipePkg::aluOp_t aluOp,
  output isaPkg::word_t   result,
  output logic            zero
);

  isaPkg::shamt_t shamt;

  assign shamt = portB[4:0];

  always_comb begin
    case (aluOp)
      pipePkg::ALU_SLL:  result = portA << shamt;
      pipePkg::ALU_SRL:  result = portA >> shamt;  // logical
      pipePkg::ALU_ADD:  result = portA + portB;
      pipePkg::ALU_SUB:  result = portA - portB;
      pipePkg::ALU_AND:  result = portA & portB;
      pipePkg::ALU_OR:   result = portA | portB;
      pipePkg::ALU_XOR:  result = portA ^ portB;
      pipePkg::ALU_NOR:  result = ~(portA | portB);
      pipePkg::ALU_SLT: begin
        result = {31'b0, $signed(portA) < $signed(portB)};
      end
      pipePkg::ALU_SLTU: begin
        result = {31'b0, portA < portB};
      end
      default:           result = '0;
    endcase
  end

  // beq and bne look at this after ALU_SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  isaPkg::word_t   instr,
  output logic            regDst,
  output logic            branch,
  output logic            bne,
  output logic            regWrite,
  output logic            aluSrc,
  output logic            jmp,
  output logic            jl,
  output logic            jmpReg,
  output logic            memToReg,
  output logic            dRen,
  output logic            dWen,
  output logic            lui,
  output logic            zeroExt,
  output logic            shiftSel,
  output pipePkg::aluOp_t aluOp
);

  isaPkg::opcode_t opcode;
  isaPkg::funct_t  funct;

  assign opcode = isaPkg::opcode_t'(instr[31:26]);
  assign funct  = isaPkg::funct_t'(instr[5:0]);

  always_comb begin
    // everything off unless decoded below, halt lands here too
    regDst   = 1'b0;
    branch   = 1'b0;
    bne      = 1'b0;
    regWrite = 1'b0;
    aluSrc   = 1'b0;
    jmp      = 1'b0;
    jl       = 1'b0;
    jmpReg   = 1'b0;
    memToReg = 1'b0;
    dRen     = 1'b0;
    dWen     = 1'b0;
    lui      = 1'b0;
    zeroExt  = 1'b0;
    shiftSel = 1'b0;
    aluOp    = pipePkg::ALU_SLL;
    case (opcode)
      isaPkg::RTYPE: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (funct)
          isaPkg::SLL: begin
            shiftSel = 1'b1;
            aluOp    = pipePkg::ALU_SLL;
          end
          isaPkg::SRL: begin
            shiftSel = 1'b1;
            aluOp    = pipePkg::ALU_SRL;
          end
          isaPkg::JR: begin
            regWrite = 1'b0;
            jmpReg   = 1'b1;
          end
          isaPkg::ADDU: aluOp = pipePkg::ALU_ADD;
          isaPkg::SUBU: aluOp = pipePkg::ALU_SUB;
          isaPkg::AND:  aluOp = pipePkg::ALU_AND;
          isaPkg::OR:   aluOp = pipePkg::ALU_OR;
          isaPkg::XOR:  aluOp = pipePkg::ALU_XOR;
          isaPkg::NOR:  aluOp = pipePkg::ALU_NOR;
          isaPkg::SLT:  aluOp = pipePkg::ALU_SLT;
          isaPkg::SLTU: aluOp = pipePkg::ALU_SLTU;
          default: begin
            regDst   = 1'b0;  // unknown funct acts as nop
            regWrite = 1'b0;
          end
        endcase
      end
      isaPkg::J:   jmp = 1'b1;
      isaPkg::JAL: begin
        jmp      = 1'b1;
        jl       = 1'b1;
        regWrite = 1'b1;
      end
      isaPkg::BEQ: begin
        branch = 1'b1;
        aluOp  = pipePkg::ALU_SUB;
      end
      isaPkg::BNE: begin
        branch = 1'b1;
        bne    = 1'b1;
        aluOp  = pipePkg::ALU_SUB;
      end
      isaPkg::ADDIU, isaPkg::SLTI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        aluOp    = (opcode == isaPkg::SLTI) ? pipePkg::ALU_SLT : pipePkg::ALU_ADD;
      end
      isaPkg::ANDI, isaPkg::ORI, isaPkg::XORI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        zeroExt  = 1'b1;
        if (opcode == isaPkg::ANDI)
          aluOp = pipePkg::ALU_AND;
        else if (opcode == isaPkg::ORI)
          aluOp = pipePkg::ALU_OR;
        else
          aluOp = pipePkg::ALU_XOR;
      end
      isaPkg::LUI: begin
        lui      = 1'b1;  // value built in write-back
        regWrite = 1'b1;
      end
      isaPkg::LW: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        memToReg = 1'b1;
        dRen     = 1'b1;
        aluOp    = pipePkg::ALU_ADD;
      end
      isaPkg::SW: begin
        aluSrc = 1'b1;
        dWen   = 1'b1;
        aluOp  = pipePkg::ALU_ADD;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/programCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module programCounter (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          ihit,
  input  isaPkg::word_t exInstr,
  input  isaPkg::word_t exImm,
  input  isaPkg::word_t exRdat1,
  input  logic          branch,
  input  logic          bne,
  input  logic          jmp,
  input  logic          jmpReg,
  input  logic          zero,
  output isaPkg::word_t pc,
  output isaPkg::word_t incPC
);

  isaPkg::word_t idIncPC, exIncPC;  // pc+4 of the ID and EX instructions
  isaPkg::word_t jumpTarget, branchTarget, nextPC;
  logic          takeBranch;

  assign incPC        = pc + 32'd4;
  assign takeBranch   = branch && (zero != bne);
  assign jumpTarget   = {exIncPC[31:28], exInstr[25:0], 2'b00};
  assign branchTarget = exIncPC + (exImm << 2);  // relative to the branch's own pc+4

  always_comb begin
    if (jmpReg)
      nextPC = exRdat1;
    else if (jmp)
      nextPC = jumpTarget;
    else if (takeBranch)
      nextPC = branchTarget;
    else
      nextPC = incPC;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc      <= pipePkg::PC_INIT;
      idIncPC <= '0;
      exIncPC <= '0;
    end else if (ihit) begin
      pc      <= nextPC;
      idIncPC <= incPC;
      exIncPC <= idIncPC;
    end
  end

  pcAligned: assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* hdl/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          ihit,
  input  logic          dhit,
  input  isaPkg::word_t imemLoad,
  input  isaPkg::word_t dmemLoad,
  output isaPkg::word_t imemAddr,
  output isaPkg::word_t dmemAddr,
  output isaPkg::word_t dmemStore,
  output logic          dmemRen,
  output logic          dmemWen,
  output logic          halt
);

  // decode outputs
  logic regDst, branch, bne, regWrite, aluSrc, jmp, jl, jmpReg;
  logic memToReg, dRen, dWen, lui, zeroExt, shiftSel;
  pipePkg::aluOp_t  aluOp;
  isaPkg::word_t    rdat1, rdat2;
  isaPkg::regAddr_t idDest;

  isaPkg::imm_t   exImmField;
  isaPkg::shamt_t exShamt;
  isaPkg::word_t  exImm, portA, portB, aluResult;
  logic           aluZero;
  isaPkg::word_t  pc, incPC, wbData;
  logic           memWbEnable;

  // pipeline registers
  isaPkg::word_t    ifIdInstr, ifIdIncPC;
  isaPkg::word_t    idExInstr, idExIncPC, idExRdat1, idExRdat2;
  isaPkg::regAddr_t idExDest;
  logic idExBranch, idExBne, idExRegWrite, idExAluSrc, idExJmp, idExJl, idExJmpReg;
  logic idExMemToReg, idExDRen, idExDWen, idExLui, idExZeroExt, idExShiftSel;
  pipePkg::aluOp_t  idExAluOp;
  isaPkg::word_t    exMemInstr, exMemIncPC, exMemAluResult, exMemRdat2;
  isaPkg::regAddr_t exMemDest;
  logic exMemRegWrite, exMemJl, exMemMemToReg, exMemDRen, exMemDWen, exMemLui;
  isaPkg::word_t    memWbInstr, memWbIncPC, memWbAluResult, memWbLoad;
  isaPkg::regAddr_t memWbDest;
  logic memWbRegWrite, memWbJl, memWbMemToReg, memWbLui;

  controlUnit control0 (
    .instr(ifIdInstr), .regDst(regDst), .branch(branch), .bne(bne), .regWrite(regWrite),
    .aluSrc(aluSrc), .jmp(jmp), .jl(jl), .jmpReg(jmpReg), .memToReg(memToReg),
    .dRen(dRen), .dWen(dWen), .lui(lui), .zeroExt(zeroExt), .shiftSel(shiftSel),
    .aluOp(aluOp)
  );

  registerFile regFile0 (
    .CLK(CLK), .nRST(nRST), .wen(memWbRegWrite), .wsel(memWbDest), .wdat(wbData),
    .rsel1(ifIdInstr[25:21]), .rsel2(ifIdInstr[20:16]), .rdat1(rdat1), .rdat2(rdat2)
  );

  alu alu0 (.portA(portA), .portB(portB), .aluOp(idExAluOp), .result(aluResult),
            .zero(aluZero));

  programCounter pc0 (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .exInstr(idExInstr), .exImm(exImm),
    .exRdat1(idExRdat1), .branch(idExBranch), .bne(idExBne), .jmp(idExJmp),
    .jmpReg(idExJmpReg), .zero(aluZero), .pc(pc), .incPC(incPC)
  );

  // destination register, jal always links to 31
  always_comb begin
    if (jl)
      idDest = isaPkg::LINK_REG;
    else if (regDst)
      idDest = ifIdInstr[15:11];
    else
      idDest = ifIdInstr[20:16];
  end

  // extender
  assign exImmField = idExInstr[15:0];
  assign exShamt    = idExInstr[10:6];
  assign exImm = idExZeroExt ? {16'b0, exImmField} : {{16{exImmField[15]}}, exImmField};

  // shifts take rt as the value and shamt as the amount
  assign portA = idExShiftSel ? idExRdat2 : idExRdat1;
  always_comb begin
    if (idExShiftSel)
      portB = {27'b0, exShamt};
    else if (idExAluSrc)
      portB = exImm;
    else
      portB = idExRdat2;
  end

  always_comb begin
    if (memWbLui)
      wbData = {memWbInstr[15:0], 16'b0};
    else if (memWbJl)
      wbData = memWbIncPC;  // link address
    else if (memWbMemToReg)
      wbData = memWbLoad;
    else
      wbData = memWbAluResult;
  end

  assign memWbEnable = ihit | dhit;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ifIdInstr <= '0;
      ifIdIncPC <= '0;
      idExInstr <= '0;
      idExIncPC <= '0;
      idExRdat1 <= '0;
      idExRdat2 <= '0;
      idExDest  <= '0;
      {idExBranch, idExBne, idExRegWrite, idExAluSrc, idExJmp, idExJl} <= '0;
      {idExJmpReg, idExMemToReg, idExDRen, idExDWen, idExLui} <= '0;
      {idExZeroExt, idExShiftSel} <= '0;
      idExAluOp <= pipePkg::ALU_SLL;
    end else if (ihit) begin
      ifIdInstr    <= imemLoad;
      ifIdIncPC    <= incPC;
      idExInstr    <= ifIdInstr;
      idExIncPC    <= ifIdIncPC;
      idExRdat1    <= rdat1;
      idExRdat2    <= rdat2;
      idExDest     <= idDest;
      idExBranch   <= branch;
      idExBne      <= bne;
      idExRegWrite <= regWrite;
      idExAluSrc   <= aluSrc;
      idExJmp      <= jmp;
      idExJl       <= jl;
      idExJmpReg   <= jmpReg;
      idExMemToReg <= memToReg;
      idExDRen     <= dRen;
      idExDWen     <= dWen;
      idExLui      <= lui;
      idExZeroExt  <= zeroExt;
      idExShiftSel <= shiftSel;
      idExAluOp    <= aluOp;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exMemInstr     <= '0;
      exMemIncPC     <= '0;
      exMemAluResult <= '0;
      exMemRdat2     <= '0;
      exMemDest      <= '0;
      {exMemRegWrite, exMemJl, exMemMemToReg, exMemDRen, exMemDWen, exMemLui} <= '0;
    end else if (ihit) begin
      exMemInstr     <= idExInstr;
      exMemIncPC     <= idExIncPC;
      exMemAluResult <= aluResult;
      exMemRdat2     <= idExRdat2;  // store data
      exMemDest      <= idExDest;
      exMemRegWrite  <= idExRegWrite;
      exMemJl        <= idExJl;
      exMemMemToReg  <= idExMemToReg;
      exMemDRen      <= idExDRen;
      exMemDWen      <= idExDWen;
      exMemLui       <= idExLui;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memWbInstr     <= '0;
      memWbIncPC     <= '0;
      memWbAluResult <= '0;
      memWbLoad      <= '0;
      memWbDest      <= '0;
      {memWbRegWrite, memWbJl, memWbMemToReg, memWbLui} <= '0;
    end else if (memWbEnable) begin
      memWbInstr     <= exMemInstr;
      memWbIncPC     <= exMemIncPC;
      memWbAluResult <= exMemAluResult;
      memWbLoad      <= dmemLoad;
      memWbDest      <= exMemDest;
      memWbRegWrite  <= exMemRegWrite;
      memWbJl        <= exMemJl;
      memWbMemToReg  <= exMemMemToReg;
      memWbLui       <= exMemLui;
    end
  end

  // halt latch, held until the next reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (memWbInstr == pipePkg::HALT_WORD)
      halt <= 1'b1;
  end

  assign imemAddr  = pc;
  assign dmemAddr  = exMemAluResult;
  assign dmemStore = exMemRdat2;
  assign dmemRen   = exMemDRen;
  assign dmemWen   = exMemDWen;

  oneDataRequest: assert property (@(posedge CLK) disable iff (!nRST) !(dmemRen && dmemWen))
    else $error("load and store requested together");

endmodule

`default_nettype wire

/* hdl/memorySystem.sv */
`timescale 1ns/1ps
`default_nettype none

module memorySystem (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              progWen,
  input  pipePkg::memAddr_t progAddr,
  input  isaPkg::word_t     progData,
  input  isaPkg::word_t     imemAddr,
  output isaPkg::word_t     imemLoad,
  output logic              ihit,
  input  logic              dmemRen,
  input  logic              dmemWen,
  input  isaPkg::word_t     dmemAddr,
  input  isaPkg::word_t     dmemStore,
  output isaPkg::word_t     dmemLoad,
  output logic              dhit
);

  isaPkg::word_t     imem [pipePkg::MEM_WORDS];
  isaPkg::word_t     dmem [pipePkg::MEM_WORDS];
  pipePkg::memAddr_t iIndex, dIndex;

  assign iIndex = imemAddr[9:2];  // word index
  assign dIndex = dmemAddr[9:2];

  // program load port
  always_ff @(posedge CLK) begin
    if (progWen)
      imem[progAddr] <= progData;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < pipePkg::MEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (dmemWen) begin
      dmem[dIndex] <= dmemStore;
    end
  end

  assign imemLoad = imem[iIndex];
  assign dmemLoad = dmem[dIndex];
  assign ihit     = 1'b1;                // same-cycle memory
  assign dhit     = dmemRen | dmemWen;

  loadOnlyInReset: assert property (@(posedge CLK) progWen |-> !nRST)
    else $error("program write while core running");

endmodule

`default_nettype wire

/* hdl/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        progWen,
  input  logic [7:0]  progAddr,
  input  logic [31:0] progData,
  output logic        storeValid,
  output logic [31:0] storeAddr,
  output logic [31:0] storeData,
  output logic        halted
);

  logic [31:0] imemAddr, imemLoad, dmemAddr, dmemStore, dmemLoad;
  logic        ihit, dhit, dmemRen, dmemWen;

  datapath dp0 (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .dhit(dhit), .imemLoad(imemLoad),
    .dmemLoad(dmemLoad), .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemStore(dmemStore),
    .dmemRen(dmemRen), .dmemWen(dmemWen), .halt(halted)
  );

  memorySystem mem0 (
    .CLK(CLK), .nRST(nRST), .progWen(progWen), .progAddr(progAddr), .progData(progData),
    .imemAddr(imemAddr), .imemLoad(imemLoad), .ihit(ihit), .dmemRen(dmemRen),
    .dmemWen(dmemWen), .dmemAddr(dmemAddr), .dmemStore(dmemStore), .dmemLoad(dmemLoad),
    .dhit(dhit)
  );

  // store watch port for the testbench
  assign storeValid = dmemWen;
  assign storeAddr  = dmemAddr;
  assign storeData  = dmemStore;

endmodule

`default_nettype wire

/* tests/cpuTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int RESET_CYCLES    = 3;
  localparam logic [31:0] SEED   = 32'hd259_c2b4;
  localparam isaPkg::word_t NOP  = 32'h0000_0000;  // sll r0, r0, 0

  logic        CLK;
  logic        nRST;
  logic        progWen;
  logic [7:0]  progAddr;
  logic [31:0] progData;
  logic        storeValid;
  logic [31:0] storeAddr;
  logic [31:0] storeData;
  logic        halted;

  isaPkg::word_t prog[$];   // program image of the current test
  logic [63:0]   expQ[$];   // expected stores as {addr, data}
  logic [63:0]   expHead;
  logic          expAny;
  logic [31:0]   rngState;
  string         testName;
  int            errCount;
  int            failedTests;

  cpuTop dut0 (
    .CLK(CLK), .nRST(nRST), .progWen(progWen), .progAddr(progAddr), .progData(progData),
    .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData), .halted(halted)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // queue head is refreshed mid-cycle, after the store of this cycle retires
  always @(negedge CLK) begin
    if (nRST && storeValid && expQ.size() != 0)
      void'(expQ.pop_front());
    expAny  = (expQ.size() != 0);
    expHead = expAny ? expQ[0] : 64'h0;
  end

  storeMatches: assert property (@(negedge CLK) disable iff (!nRST)
      storeValid && expAny |-> {storeAddr, storeData} == expHead)
    else begin
      errCount++;
      $display("mismatch in %s: expected addr %h data %h, actual addr %h data %h",
               testName, $sampled(expHead[63:32]), $sampled(expHead[31:0]),
               $sampled(storeAddr), $sampled(storeData));
    end

  storeExpected: assert property (@(negedge CLK) disable iff (!nRST) storeValid |-> expAny)
    else begin
      errCount++;
      $display("%s: unexpected store of %h to %h", testName, $sampled(storeData),
               $sampled(storeAddr));
    end

  allStoresSeen: assert property (@(negedge CLK) disable iff (!nRST) $rose(halted) |-> !expAny)
    else begin
      errCount++;
      $display("%s: core halted with %0d expected stores missing", testName, expQ.size());
    end

  haltedHolds: assert property (@(negedge CLK) disable iff (!nRST) halted |=> halted)
    else begin
      errCount++;
      $display("%s: halted dropped without a reset", testName);
    end

  haltedClearAfterReset: assert property (@(negedge CLK) $rose(nRST) |-> !halted)
    else begin
      errCount++;
      $display("%s: halted still high after reset", testName);
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic isaPkg::word_t nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  function automatic isaPkg::word_t encodeR(input isaPkg::funct_t funct,
      input isaPkg::regAddr_t rs, input isaPkg::regAddr_t rt, input isaPkg::regAddr_t rd,
      input isaPkg::shamt_t shamt);
    return {6'b000000, rs, rt, rd, shamt, funct};
  endfunction

  function automatic isaPkg::word_t encodeI(input isaPkg::opcode_t op,
      input isaPkg::regAddr_t rs, input isaPkg::regAddr_t rt, input isaPkg::imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic isaPkg::word_t encodeJ(input isaPkg::opcode_t op, input logic [25:0] index);
    return {op, index};
  endfunction

  task automatic startProgram();
    prog.delete();
    expQ.delete();
  endtask

  // four nops keep the next reader clear of the write-back
  task automatic emit(input isaPkg::word_t instr);
    prog.push_back(instr);
    repeat (4) prog.push_back(NOP);
  endtask

  task automatic expectStore(input isaPkg::imm_t off, input isaPkg::word_t value);
    expQ.push_back({16'h0000, off, value});
  endtask

  task automatic loadConst(input isaPkg::regAddr_t rt, input isaPkg::word_t value);
    emit(encodeI(isaPkg::LUI, 5'd0, rt, value[31:16]));
    emit(encodeI(isaPkg::ORI, rt, rt, value[15:0]));
  endtask

  task automatic emitStore(input isaPkg::regAddr_t rt, input isaPkg::imm_t off,
                           input isaPkg::word_t value);
    emit(encodeI(isaPkg::SW, 5'd0, rt, off));
    expectStore(off, value);
  endtask

  // jump word, a store of r1 in each of the two slots, then a store of r4
  // that only runs when control falls through; target is frame start + 16
  task automatic emitSkipFrame(input isaPkg::word_t jumpWord, input isaPkg::imm_t slotOff,
      input isaPkg::word_t slotValue, input isaPkg::imm_t pathOff,
      input isaPkg::word_t pathValue, input logic pathRuns);
    prog.push_back(jumpWord);
    prog.push_back(encodeI(isaPkg::SW, 5'd0, 5'd1, slotOff));
    prog.push_back(encodeI(isaPkg::SW, 5'd0, 5'd1, slotOff + 16'h0040));  // second slot
    prog.push_back(encodeI(isaPkg::SW, 5'd0, 5'd4, pathOff));
    repeat (4) prog.push_back(NOP);
    expectStore(slotOff, slotValue);
    expectStore(slotOff + 16'h0040, slotValue);
    if (pathRuns)
      expectStore(pathOff, pathValue);
  endtask

  // halt, then spin on a jump to itself so nothing past it is fetched
  task automatic finishProgram();
    int p;
    emit(pipePkg::HALT_WORD);
    p = prog.size();
    prog.push_back(encodeJ(isaPkg::J, 26'(p)));
    prog.push_back(NOP);
    prog.push_back(NOP);
  endtask

  task automatic buildArithmetic();
    isaPkg::word_t a, b, tmp;
    isaPkg::shamt_t sh;
    a   = nextRandom() | 32'h8000_0000;  // negative signed, large unsigned
    b   = nextRandom() & 32'h7fff_ffff;
    tmp = nextRandom();
    sh  = tmp[4:0] | 5'd1;
    startProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emit(encodeR(isaPkg::ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0100, a + b);
    emit(encodeR(isaPkg::SUBU, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0104, a - b);
    emit(encodeR(isaPkg::AND, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0108, a & b);
    emit(encodeR(isaPkg::OR, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h010c, a | b);
    emit(encodeR(isaPkg::XOR, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0110, a ^ b);
    emit(encodeR(isaPkg::NOR, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0114, ~(a | b));
    emit(encodeR(isaPkg::SLT, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h0118, 32'd1);  // a below b only as signed
    emit(encodeR(isaPkg::SLTU, 5'd1, 5'd2, 5'd3, 5'd0));
    emitStore(5'd3, 16'h011c, 32'd0);
    emit(encodeR(isaPkg::SLL, 5'd0, 5'd1, 5'd3, sh));  // shifts take rt
    emitStore(5'd3, 16'h0120, a << sh);
    emit(encodeR(isaPkg::SRL, 5'd0, 5'd1, 5'd3, sh));
    emitStore(5'd3, 16'h0124, a >> sh);
    finishProgram();
  endtask

  task automatic buildImmediates();
    isaPkg::word_t a, tmp;
    isaPkg::imm_t imm;
    a   = nextRandom();
    tmp = nextRandom();
    imm = tmp[15:0] | 16'h8000;  // top bit set so the two extensions differ
    startProgram();
    loadConst(5'd1, a);
    emit(encodeI(isaPkg::ORI, 5'd0, 5'd2, 16'h0005));
    emit(encodeI(isaPkg::ADDIU, 5'd1, 5'd3, imm));
    emitStore(5'd3, 16'h0100, a + {16'hffff, imm});
    emit(encodeI(isaPkg::SLTI, 5'd2, 5'd4, 16'hfff0));  // 5 < -16
    emitStore(5'd4, 16'h0104, 32'd0);
    emit(encodeI(isaPkg::SLTI, 5'd2, 5'd5, 16'h0007));
    emitStore(5'd5, 16'h0108, 32'd1);
    emit(encodeI(isaPkg::ANDI, 5'd1, 5'd6, imm));
    emitStore(5'd6, 16'h010c, a & {16'h0000, imm});
    emit(encodeI(isaPkg::ORI, 5'd1, 5'd7, imm));
    emitStore(5'd7, 16'h0110, a | {16'h0000, imm});
    emit(encodeI(isaPkg::XORI, 5'd1, 5'd8, imm));
    emitStore(5'd8, 16'h0114, a ^ {16'h0000, imm});
    emit(encodeI(isaPkg::LUI, 5'd0, 5'd9, imm));
    emitStore(5'd9, 16'h0118, {imm, 16'h0000});
    finishProgram();
  endtask

  task automatic buildLoadStore();
    isaPkg::word_t a, b;
    a = nextRandom();
    b = nextRandom();
    startProgram();
    loadConst(5'd1, a);
    loadConst(5'd2, b);
    emitStore(5'd1, 16'h0040, a);
    emitStore(5'd2, 16'h0044, b);
    emit(encodeI(isaPkg::LW, 5'd0, 5'd3, 16'h0040));
    emit(encodeI(isaPkg::LW, 5'd0, 5'd4, 16'h0044));
    emitStore(5'd3, 16'h0048, a);
    emitStore(5'd4, 16'h004c, b);
    emit(encodeI(isaPkg::ADDIU, 5'd1, 5'd0, 16'h1234));  // r0 must ignore this
    emitStore(5'd0, 16'h0050, 32'd0);
    finishProgram();
  endtask

  task automatic buildBranches();
    isaPkg::word_t a, b;
    a = nextRandom();
    b = nextRandom();
    startProgram();
    loadConst(5'd1, a);
    emit(encodeR(isaPkg::ADDU, 5'd1, 5'd0, 5'd2, 5'd0));  // r2 equals r1
    emit(encodeI(isaPkg::XORI, 5'd1, 5'd3, 16'h0001));     // r3 differs
    loadConst(5'd4, b);
    emitSkipFrame(encodeI(isaPkg::BEQ, 5'd1, 5'd2, 16'd3), 16'h0100, a, 16'h0104, b, 1'b0);
    emitSkipFrame(encodeI(isaPkg::BEQ, 5'd1, 5'd3, 16'd3), 16'h0108, a, 16'h010c, b, 1'b1);
    emitSkipFrame(encodeI(isaPkg::BNE, 5'd1, 5'd3, 16'd3), 16'h0110, a, 16'h0114, b, 1'b0);
    emitSkipFrame(encodeI(isaPkg::BNE, 5'd1, 5'd2, 16'd3), 16'h0118, a, 16'h011c, b, 1'b1);
    finishProgram();
  endtask

  task automatic buildJumps();
    isaPkg::word_t a, b;
    int p;
    a = nextRandom();
    b = nextRandom();
    startProgram();
    loadConst(5'd1, a);
    loadConst(5'd4, b);
    p = prog.size();
    emitSkipFrame(encodeJ(isaPkg::J, 26'(p + 4)), 16'h0100, a, 16'h0104, b, 1'b0);
    p = prog.size() + 5;  // frame starts after the target load
    emit(encodeI(isaPkg::ORI, 5'd0, 5'd5, 16'((p + 4) * 4)));
    emitSkipFrame(encodeR(isaPkg::JR, 5'd5, 5'd0, 5'd0, 5'd0), 16'h0108, a, 16'h010c, b,
                  1'b0);
    p = prog.size();
    emitSkipFrame(encodeJ(isaPkg::JAL, 26'(p + 4)), 16'h0110, a, 16'h0114, b, 1'b0);
    emitStore(isaPkg::LINK_REG, 16'h0118, 32'((p + 1) * 4));
    finishProgram();
  endtask

  task automatic buildHaltReset();
    isaPkg::word_t a;
    a = nextRandom();
    startProgram();
    loadConst(5'd1, a);
    emitStore(5'd1, 16'h01f0, a);
    finishProgram();
  endtask

  // program goes in while the core sits in reset
  task automatic loadAndReset();
    @(posedge CLK);
    nRST <= 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge CLK);
      progWen  <= 1'b1;
      progAddr <= i[7:0];
      progData <= prog[i];
    end
    @(posedge CLK);
    progWen <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic runTest(input string name, input int holdCycles);
    int errBefore;
    errBefore = errCount;
    testName  = name;
    loadAndReset();
    do @(negedge CLK); while (!halted);
    repeat (holdCycles) @(negedge CLK);
    if (errCount == errBefore) begin
      $display("test %-12s passed", name);
    end else begin
      failedTests++;
      $display("test %-12s failed with %0d errors", name, errCount - errBefore);
    end
  endtask

  initial begin
    CLK         = 1'b0;
    nRST        = 1'b0;
    progWen     = 1'b0;
    progAddr    = 8'h00;
    progData    = 32'h0;
    expAny      = 1'b0;
    expHead     = 64'h0;
    rngState    = SEED;
    errCount    = 0;
    failedTests = 0;
    testName    = "none";
    buildArithmetic();
    runTest("rtype", 4);
    buildImmediates();
    runTest("immediate", 4);
    buildLoadStore();
    runTest("loadstore", 4);
    buildBranches();
    runTest("branch", 4);
    buildJumps();
    runTest("jump", 4);
    buildHaltReset();
    runTest("haltreset", 40);  // long hold so halted is watched for a while
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failedTests, errCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog expired, test %s never reached halt", testName);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/controlUnit.sv
hdl/programCounter.sv
hdl/datapath.sv
hdl/memorySystem.sv
hdl/cpuTop.sv
tests/cpuTopTb.sv

/* Bender.yml */
package:
  name: pipelined_cpu

sources:
  - files:
      - hdl/isaPkg.sv
      - hdl/pipePkg.sv
      - hdl/registerFile.sv
      - hdl/alu.sv
      - hdl/controlUnit.sv
      - hdl/programCounter.sv
      - hdl/datapath.sv
      - hdl/memorySystem.sv
      - hdl/cpuTop.sv
  - target: test
    files:
      - tests/cpuTopTb.sv
